/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module rvCoreTb -f sim.f -o rvCoreTb
	./obj_dir/rvCoreTb

clean:
	rm -rf obj_dir

/* alu.sv */
module alu import rvCorePkg::*; (
    input  wordT     srcA,
    input  wordT     srcB,
    input  aluCtrlT  aluCtrl,
    output wordT     result,
    output cmpFlagsT cmpFlags
);

    logic isEq;
    logic isLt;
    logic isLtu;

    assign isEq  = (srcA == srcB);
    assign isLt  = ($signed(srcA) < $signed(srcB));
    assign isLtu = (srcA < srcB);

    always_comb begin
        cmpFlags            = '0;
        cmpFlags[cmpEqBit]  = isEq;
        cmpFlags[cmpLtBit]  = isLt;
        cmpFlags[cmpLtuBit] = isLtu;
    end

    always_comb begin
        case (aluCtrl)
            aluAdd:  result = srcA + srcB;
            aluSub:  result = srcA - srcB;
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluXor:  result = srcA ^ srcB;
            aluSlt:  result = {31'b0, isLt};
            aluSltu: result = {31'b0, isLtu};
            default: result = '0;
        endcase
    end

endmodule

/* aluDecoder.sv */
module aluDecoder import rvCorePkg::*, rvIsaPkg::*; (
    input  aluOpT   aluOp,
    input  funct3T  funct3,
    input  logic    funct75,
    input  logic    opFunct75,
    output aluCtrlT aluCtrl
);

    logic isSub;

    // Only R-type carries a real funct7
    assign isSub = funct75 & opFunct75;

    always_comb begin
        case (aluOp)
            aluOpAdd: aluCtrl = aluAdd;
            aluOpSub: aluCtrl = aluSub;
            default: begin
                case (funct3)
                    f3AddSub: aluCtrl = isSub ? aluSub : aluAdd;
                    f3Slt:    aluCtrl = aluSlt;
                    f3Sltu:   aluCtrl = aluSltu;
                    f3Xor:    aluCtrl = aluXor;
                    f3Or:     aluCtrl = aluOr;
                    f3And:    aluCtrl = aluAnd;
                    default:  aluCtrl = aluAdd; // Shifts unsupported
                endcase
            end
        endcase
    end

endmodule

/* control.sv */
module control import rvCorePkg::*, rvIsaPkg::*; (
    input  wordT      instr,
    input  cmpFlagsT  cmpFlags,
    output logic      regWrite,
    output logic      aluSrc,
    output logic      memWrite,
    output logic      pcSrc,
    output aluCtrlT   aluCtrl,
    output immSrcT    immSrc,
    output resultSrcT resultSrc,
    output funct3T    funct3
);

    opcodeT opcode;
    logic   branch;
    logic   jump;
    aluOpT  aluOp;
    logic   taken;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    mainDecoder mainDec (
        .opcode(opcode),
        .regWrite(regWrite),
        .aluSrc(aluSrc),
        .memWrite(memWrite),
        .branch(branch),
        .jump(jump),
        .resultSrc(resultSrc),
        .immSrc(immSrc),
        .aluOp(aluOp)
    );

    aluDecoder aluDec (
        .aluOp(aluOp),
        .funct3(funct3),
        .funct75(instr[30]),
        .opFunct75(opcode[5]),
        .aluCtrl(aluCtrl)
    );

    always_comb begin
        case (funct3)
            f3Beq:   taken = cmpFlags[cmpEqBit];
            f3Bne:   taken = ~cmpFlags[cmpEqBit];
            f3Blt:   taken = cmpFlags[cmpLtBit];
            f3Bge:   taken = ~cmpFlags[cmpLtBit];
            f3Bltu:  taken = cmpFlags[cmpLtuBit];
            f3Bgeu:  taken = ~cmpFlags[cmpLtuBit];
            default: taken = 1'b0;
        endcase
    end

    assign pcSrc = jump | (branch & taken);

endmodule

/* dataMem.sv */
module dataMem import rvCorePkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic wrEn,
    input  wordT addr,
    input  wordT wrData,
    output wordT rdData
);

    localparam int idxBits = $clog2(memWordsLp);

    wordT                 mem [memWordsLp];
    logic [idxBits-1:0]   wordIdx;

    assign wordIdx = addr[idxBits+1:2]; // Byte offset dropped

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < memWordsLp; i++) begin
                mem[i] <= '0;
            end
        end else if (wrEn) begin
            mem[wordIdx] <= wrData;
        end
    end

    assign rdData = mem[wordIdx];

endmodule

/* immExtend.sv */
module immExtend import rvCorePkg::*; (
    input  wordT   instr,
    input  immSrcT immSrc,
    output wordT   imm
);

    always_comb begin
        case (immSrc)
            immI: imm = {{20{instr[31]}}, instr[31:20]};
            immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            immJ: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

/* mainDecoder.sv */
module mainDecoder import rvCorePkg::*, rvIsaPkg::*; (
    input  opcodeT    opcode,
    output logic      regWrite,
    output logic      aluSrc,
    output logic      memWrite,
    output logic      branch,
    output logic      jump,
    output resultSrcT resultSrc,
    output immSrcT    immSrc,
    output aluOpT     aluOp
);

    always_comb begin
        // Defaults act as a no-op
        regWrite  = 1'b0;
        aluSrc    = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        resultSrc = resAlu;
        immSrc    = immI;
        aluOp     = aluOpAdd;

        case (opcode)
            opR: begin
                regWrite = 1'b1;
                aluOp    = aluOpFunct;
            end
            opImm: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluOpFunct;
            end
            opLoad: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = resMem;
            end
            opStore: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = immS;
            end
            opBranch: begin
                branch = 1'b1;
                immSrc = immB;
                aluOp  = aluOpSub;
            end
            opJal: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                immSrc    = immJ;
                resultSrc = resPc4; // Link address
            end
            default: ;
        endcase
    end

endmodule

/* regFile.sv */
module regFile import rvCorePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  regAddrT rs1,
    input  regAddrT rs2,
    input  regAddrT rd,
    input  logic    wrEn,
    input  wordT    wrData,
    output wordT    rd1,
    output wordT    rd2
);

    wordT regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && rd != '0) begin // x0 never written
            regs[rd] <= wrData;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* rvCore.sv */
module rvCore import rvCorePkg::*, rvIsaPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  wordT    instr,
    output wordT    pc,
    output logic    regWrEn,
    output regAddrT regWrAddr,
    output wordT    regWrData,
    output logic    memWrEn,
    output wordT    memAddr,
    output wordT    memWData
);

    logic      aluSrc;
    logic      memWrite;
    logic      pcSrc;
    aluCtrlT   aluCtrl;
    immSrcT    immSrc;
    resultSrcT resultSrc;
    funct3T    funct3;
    cmpFlagsT  cmpFlags;

    wordT imm;
    wordT rd1;
    wordT rd2;
    wordT srcB;
    wordT aluResult;
    wordT memRdData;
    wordT pcPlus4;
    wordT pcTarget;
    wordT pcNext;

    control ctrl0 (
        .instr(instr),
        .cmpFlags(cmpFlags),
        .regWrite(regWrEn),
        .aluSrc(aluSrc),
        .memWrite(memWrite),
        .pcSrc(pcSrc),
        .aluCtrl(aluCtrl),
        .immSrc(immSrc),
        .resultSrc(resultSrc),
        .funct3(funct3)
    );

    immExtend immExt0 (
        .instr(instr),
        .immSrc(immSrc),
        .imm(imm)
    );

    regFile regFile0 (
        .clk(clk),
        .rstN(rstN),
        .rs1(instr[19:15]),
        .rs2(instr[24:20]),
        .rd(regWrAddr),
        .wrEn(regWrEn),
        .wrData(regWrData),
        .rd1(rd1),
        .rd2(rd2)
    );

    assign srcB = aluSrc ? imm : rd2;

    alu alu0 (
        .srcA(rd1),
        .srcB(srcB),
        .aluCtrl(aluCtrl),
        .result(aluResult),
        .cmpFlags(cmpFlags)
    );

    dataMem dataMem0 (
        .clk(clk),
        .rstN(rstN),
        .wrEn(memWrEn),
        .addr(aluResult),
        .wrData(rd2),
        .rdData(memRdData)
    );

    assign memWrEn   = memWrite & (funct3 == f3Word); // sw only
    assign memAddr   = aluResult;
    assign memWData  = rd2;
    assign regWrAddr = instr[11:7];

    always_comb begin
        case (resultSrc)
            resMem:  regWrData = memRdData;
            resPc4:  regWrData = pcPlus4;
            default: regWrData = aluResult;
        endcase
    end

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;
    assign pcNext   = pcSrc ? pcTarget : pcPlus4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

/* rvCorePkg.sv */
package rvCorePkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;
    typedef logic [2:0]  aluCtrlT;
    typedef logic [1:0]  aluOpT;
    typedef logic [2:0]  immSrcT;
    typedef logic [1:0]  resultSrcT;
    typedef logic [2:0]  cmpFlagsT;

    localparam aluCtrlT aluAdd  = 3'd0;
    localparam aluCtrlT aluSub  = 3'd1;
    localparam aluCtrlT aluAnd  = 3'd2;
    localparam aluCtrlT aluOr   = 3'd3;
    localparam aluCtrlT aluXor  = 3'd4;
    localparam aluCtrlT aluSlt  = 3'd5;
    localparam aluCtrlT aluSltu = 3'd6;

    localparam aluOpT aluOpAdd   = 2'b00; // Address calc
    localparam aluOpT aluOpSub   = 2'b01; // Branch compare
    localparam aluOpT aluOpFunct = 2'b10;

    localparam immSrcT immI = 3'd0;
    localparam immSrcT immS = 3'd1;
    localparam immSrcT immB = 3'd2;
    localparam immSrcT immJ = 3'd3;

    localparam resultSrcT resAlu = 2'd0;
    localparam resultSrcT resMem = 2'd1;
    localparam resultSrcT resPc4 = 2'd2;

    // Bit positions in cmpFlagsT
    localparam int cmpEqBit  = 0;
    localparam int cmpLtBit  = 1;
    localparam int cmpLtuBit = 2;

    localparam int memWordsLp = 64;

endpackage

/* rvCoreTb.sv */
module rvCoreTb import rvCorePkg::*, rvIsaPkg::*; ();

    localparam int numInstr   = 2000;
    localparam int cycleLimit = numInstr + 100; // Reset plus some slack

    logic    clk;
    logic    rstN;
    wordT    instr;
    wordT    pc;
    logic    regWrEn;
    regAddrT regWrAddr;
    wordT    regWrData;
    logic    memWrEn;
    wordT    memAddr;
    wordT    memWData;

    tbClock clkGen (
        .clk(clk),
        .rstN(rstN)
    );

    rvCore dut0 (
        .clk(clk),
        .rstN(rstN),
        .instr(instr),
        .pc(pc),
        .regWrEn(regWrEn),
        .regWrAddr(regWrAddr),
        .regWrData(regWrData),
        .memWrEn(memWrEn),
        .memAddr(memAddr),
        .memWData(memWData)
    );

    logic [31:0] lfsr = 32'h886fd35f;
    int          cycles = 0;

    // Reference model state
    wordT mPc;
    wordT mRegs [32];
    wordT mMem [memWordsLp];

    // Fields of the instruction in flight
    int      kind;
    regAddrT rd;
    regAddrT rs1;
    regAddrT rs2;
    funct3T  f3;
    logic    isSub;
    wordT    imm;
    wordT    instrWord;

    // One LFSR step per returned bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        logic        outBit;
        v = '0;
        for (int i = 0; i < n; i++) begin
            outBit = lfsr[0];
            lfsr   = lfsr >> 1;
            if (outBit)
                lfsr = lfsr ^ 32'hD0000001;
            v = {v[30:0], outBit};
        end
        return v;
    endfunction

    function automatic funct3T pickAluF3();
        funct3T v;
        v = funct3T'(takeBits(3));
        if (v == 3'b001)
            v = f3AddSub; // Shift codes folded away
        else if (v == 3'b101)
            v = f3Xor;
        return v;
    endfunction

    function automatic funct3T pickBranchF3();
        funct3T v;
        v = funct3T'(takeBits(3));
        if (v == 3'b010)
            v = f3Beq;
        else if (v == 3'b011)
            v = f3Bne;
        return v;
    endfunction

    function automatic wordT aluRef(input funct3T op, input logic sub, input wordT a,
                                    input wordT b);
        case (op)
            f3AddSub: return sub ? a - b : a + b;
            f3Slt:    return {31'b0, $signed(a) < $signed(b)};
            f3Sltu:   return {31'b0, a < b};
            f3Xor:    return a ^ b;
            f3Or:     return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input funct3T op, input wordT a, input wordT b);
        case (op)
            f3Beq:   return a == b;
            f3Bne:   return a != b;
            f3Blt:   return $signed(a) < $signed(b);
            f3Bge:   return $signed(a) >= $signed(b);
            f3Bltu:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic checkAddr(input string name, input regAddrT got, input regAddrT exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic makeInstr();
        logic [11:0] imm12;
        logic [3:0]  step;
        kind  = int'(takeBits(3));
        rd    = regAddrT'(takeBits(5));
        rs1   = regAddrT'(takeBits(5));
        rs2   = regAddrT'(takeBits(5));
        isSub = 1'b0;
        imm   = '0;
        case (kind)
            0, 1: begin
                f3        = pickAluF3();
                isSub     = (f3 == f3AddSub) && (takeBits(1) == 32'd1);
                instrWord = {1'b0, isSub, 5'b0, rs2, rs1, f3, rd, opR};
            end
            2, 3: begin
                f3        = pickAluF3();
                imm12     = 12'(takeBits(12));
                imm       = {{20{imm12[11]}}, imm12};
                instrWord = {imm12, rs1, f3, rd, opImm};
            end
            4, 5: begin
                rs1   = '0; // Base x0 with an aligned offset
                f3    = f3Word;
                imm12 = {4'b0, 6'(takeBits(6)), 2'b0};
                imm   = {20'b0, imm12};
                if (kind == 4)
                    instrWord = {imm12, rs1, f3, rd, opLoad};
                else
                    instrWord = {imm12[11:5], rs2, rs1, f3, imm12[4:0], opStore};
            end
            6: begin
                f3        = pickBranchF3();
                step      = 4'(takeBits(4));
                imm       = {{25{step[3]}}, step, 3'b0};
                instrWord = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
            end
            default: begin
                step      = 4'(takeBits(4));
                imm       = {{25{step[3]}}, step, 3'b0};
                instrWord = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
            end
        endcase
    endtask

    // Compare the settled outputs, then retire the instruction in the model
    task automatic checkAndStep();
        wordT a;
        wordT b;
        wordT res;
        wordT nextPc;
        logic expRegWr;
        logic expMemWr;
        a        = mRegs[rs1];
        b        = mRegs[rs2];
        res      = '0;
        nextPc   = mPc + 32'd4;
        expMemWr = 1'b0;
        case (kind)
            0, 1: res = aluRef(f3, isSub, a, b);
            2, 3: res = aluRef(f3, 1'b0, a, imm);
            4:    res = mMem[imm[7:2]];
            5:    expMemWr = 1'b1;
            6: begin
                if (branchTaken(f3, a, b))
                    nextPc = mPc + imm;
            end
            default: begin
                res    = mPc + 32'd4; // Link
                nextPc = mPc + imm;
            end
        endcase
        expRegWr = (kind != 5) && (kind != 6);

        checkWord("pc", pc, mPc);
        checkBit("regWrEn", regWrEn, expRegWr);
        checkBit("memWrEn", memWrEn, expMemWr);
        if (expRegWr) begin
            checkAddr("regWrAddr", regWrAddr, rd);
            checkWord("regWrData", regWrData, res);
        end
        if (expMemWr) begin
            checkWord("memAddr", memAddr, imm);
            checkWord("memWData", memWData, b);
        end

        if (expRegWr && rd != '0)
            mRegs[rd] = res;
        if (expMemWr)
            mMem[imm[7:2]] = b;
        mPc = nextPc;
    endtask

    initial begin
        instr = '0;
        mPc   = '0;
        foreach (mRegs[i])
            mRegs[i] = '0;
        foreach (mMem[i])
            mMem[i] = '0;

        repeat (2) begin
            @(negedge clk);
            checkWord("pc", pc, '0);
            checkBit("regWrEn", regWrEn, 1'b0);
            checkBit("memWrEn", memWrEn, 1'b0);
        end

        wait (rstN === 1'b1);
        for (int n = 0; n < numInstr; n++) begin
            makeInstr();
            instr <= instrWord;
            @(negedge clk);
            checkAndStep();
            @(posedge clk);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: instruction stream did not finish within %0d cycles",
                     cycleLimit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

endmodule

/* rvIsaPkg.sv */
package rvIsaPkg;

    typedef logic [6:0] opcodeT;
    typedef logic [2:0] funct3T;

    // Major opcodes
    localparam opcodeT opR      = 7'b0110011;
    localparam opcodeT opImm    = 7'b0010011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opJal    = 7'b1101111;

    // Branch conditions
    localparam funct3T f3Beq  = 3'b000;
    localparam funct3T f3Bne  = 3'b001;
    localparam funct3T f3Blt  = 3'b100;
    localparam funct3T f3Bge  = 3'b101;
    localparam funct3T f3Bltu = 3'b110;
    localparam funct3T f3Bgeu = 3'b111;

    // Register and immediate ALU ops
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Sltu   = 3'b011;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    // Width code of word loads and stores
    localparam funct3T f3Word = 3'b010;

endpackage

/* sim.f */
rvIsaPkg.sv
rvCorePkg.sv
mainDecoder.sv
aluDecoder.sv
control.sv
immExtend.sv
alu.sv
regFile.sv
dataMem.sv
rvCore.sv
tbClock.sv
rvCoreTb.sv

/* tbClock.sv */
module tbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule
